// File: common/merge_consts.svh
// Size constants of the stream merger: source count, queue depth and payload width
`ifndef MERGE_CONSTS_SVH
`define MERGE_CONSTS_SVH

// Number of input sources
`define MERGE_SOURCES 4

// Log2 of each queue's depth, 4 words per queue
`define MERGE_LOG_DEPTH 2

// Payload width of one word
`define MERGE_WIDTH 32

`endif

// File: common/merge_pkg.sv
// Types of the stream merger: payload word, source index, source mask, queue count
`include "merge_consts.svh"

package merge_pkg;

   // One payload word
   typedef logic [`MERGE_WIDTH-1:0] word_t;

   // Index of a source
   typedef logic [$clog2(`MERGE_SOURCES)-1:0] src_t;

   // One bit per source
   typedef logic [`MERGE_SOURCES-1:0] src_mask_t;

   // Queue occupancy, 0 up to the full depth
   typedef logic [`MERGE_LOG_DEPTH:0] qcount_t;

endpackage

// File: common/queue_if.sv
// Interface between queue bank, arbiter and output stage, with its modports
`include "merge_consts.svh"

interface queue_if import merge_pkg::*; ();

   // Head word of every queue
   word_t [`MERGE_SOURCES-1:0] head;

   // Queues holding at least one word
   src_mask_t nonempty;

   // Arbiter choice
   src_t grant;
   logic grant_valid;

   // Granted queue dequeues on this edge
   logic pop;

   modport bank (
      output head,
      output nonempty,
      input  pop,
      input  grant
   );

   modport arb (
      input  nonempty,
      input  pop,
      output grant,
      output grant_valid
   );

   modport outs (
      input  head,
      input  grant,
      input  grant_valid,
      output pop
   );

endinterface

// File: queue_bank/queue_bank.sv
// Bank of per-source FWFT queues feeding heads and occupancy to the arbiter
`include "merge_consts.svh"

module queue_bank import merge_pkg::*; (
   input  logic clk,
   input  logic rstn,
   input  src_mask_t in_wr,
   input  logic [`MERGE_SOURCES*`MERGE_WIDTH-1:0] in_data,
   output src_mask_t in_full,
   queue_if.bank q
);

   localparam int DEPTH = 1 << `MERGE_LOG_DEPTH;

   src_mask_t q_empty;
   src_mask_t q_rd;
   qcount_t q_size [`MERGE_SOURCES];

   for (genvar i = 0; i < `MERGE_SOURCES; i++) begin : g_queue
      // Only the granted queue dequeues
      assign q_rd[i] = q.pop && (q.grant == src_t'(i));

      fwft_fifo #(
         .WIDTH(`MERGE_WIDTH),
         .LOG_DEPTH(`MERGE_LOG_DEPTH)
      ) u_fifo (
         .clk(clk),
         .rstn(rstn),
         .wr_en(in_wr[i]),
         .rd_en(q_rd[i]),
         .wr_data(in_data[i*`MERGE_WIDTH +: `MERGE_WIDTH]),
         .full(in_full[i]),
         .empty(q_empty[i]),
         .rd_data(q.head[i]),
         .size(q_size[i])
      );

      // Count and pointer flags agree
      a_count_flags: assert property (@(posedge clk) disable iff (!rstn)
         (q.nonempty[i] == (q_size[i] != '0)) &&
         (in_full[i] == (q_size[i] == qcount_t'(DEPTH))))
         else $error("queue_bank: occupancy of queue %0d disagrees with flags", i);
   end

   assign q.nonempty = ~q_empty;

endmodule

// File: run.sh
#!/bin/sh
# Build the stream merger testbench with Verilator, run it and scan the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module stream_merge_tb -f tb.f -o sim_tb \
   && ./obj_dir/sim_tb > sim.log 2>&1 || echo "TEST FAILED" >> sim.log
cat sim.log
! grep -q "TEST FAILED" sim.log

// File: tb.f
+incdir+common
common/merge_pkg.sv
common/queue_if.sv
verilog/fwft_fifo.sv
queue_bank/queue_bank.sv
verilog/rr_arbiter.sv
verilog/out_stage.sv
verilog/stream_merge.sv
verif/tb_clk.sv
verif/stream_merge_check.sv
verif/stream_merge_tb.sv

// File: verif/stream_merge_check.sv
// Checker: per-source reference queues, output compare and full-flag rules
`include "merge_consts.svh"

module stream_merge_check import merge_pkg::*; (
   input  logic clk,
   input  logic rstn,
   input  src_mask_t in_wr,
   input  logic [`MERGE_SOURCES*`MERGE_WIDTH-1:0] in_data,
   input  src_mask_t in_full,
   input  logic out_valid,
   input  logic out_ready,
   input  word_t out_data,
   input  src_t out_src,
   input  int test_id,
   input  logic order_en,
   output int pending,
   output int errors
);

   localparam int DEPTH = 1 << `MERGE_LOG_DEPTH;

   word_t ref_q [`MERGE_SOURCES][$];
   src_mask_t ref_mask;
   int last_src;
   int exp_src;
   logic seen_write;
   logic stalled;
   word_t held_data;
   src_t held_src;
   word_t exp_word;

   // First non-empty source after the last one delivered, in cyclic order
   function automatic int next_source(input src_mask_t mask, input int last);
      int s;
      for (int k = 1; k <= `MERGE_SOURCES; k++) begin
         s = (last + k) % `MERGE_SOURCES;
         if (mask[s])
            return s;
      end
      return -1;
   endfunction

   function automatic string test_name(input int id);
      case (id)
         1: return "reset";
         2: return "single_source";
         3: return "saturation";
         4: return "back_pressure";
         5: return "fill";
         default: return "random_mix";
      endcase
   endfunction

   always @(posedge clk) begin
      if (!rstn) begin
         seen_write = 1'b0;
         stalled = 1'b0;
         last_src = `MERGE_SOURCES - 1;
      end else begin
         if (!seen_write && (out_valid || in_full != '0)) begin
            $display("out_valid or in_full rose before the first write");
            errors++;
         end
         // Queue plus output stage bound the undelivered count per source
         for (int i = 0; i < `MERGE_SOURCES; i++) begin
            if (in_full[i] && ref_q[i].size() < DEPTH) begin
               $display("in_full[%0d] high with only %0d words undelivered", i, ref_q[i].size());
               errors++;
            end
            if (!in_full[i] && ref_q[i].size() >= DEPTH + 2) begin
               $display("in_full[%0d] low with %0d words undelivered", i, ref_q[i].size());
               errors++;
            end
         end
         if (stalled && !(out_valid && out_data == held_data && out_src == held_src)) begin
            $display("error %s: stalled word expected %h/%0d actual %h/%0d",
               test_name(test_id), held_data, held_src, out_data, out_src);
            errors++;
         end
         if (out_valid && out_ready) begin
            for (int i = 0; i < `MERGE_SOURCES; i++)
               ref_mask[i] = (ref_q[i].size() != 0);
            exp_src = next_source(ref_mask, last_src);
            if (order_en && exp_src != int'(out_src)) begin
               $display("error %s: source expected %0d actual %0d",
                  test_name(test_id), exp_src, out_src);
               errors++;
            end
            if (ref_q[out_src].size() == 0) begin
               $display("word %h came from source %0d, which had nothing queued", out_data, out_src);
               errors++;
            end else begin
               exp_word = ref_q[out_src].pop_front();
               if (exp_word != out_data) begin
                  $display("error %s: data from source %0d expected %h actual %h",
                     test_name(test_id), out_src, exp_word, out_data);
                  errors++;
               end
            end
            last_src = int'(out_src);
         end
         for (int i = 0; i < `MERGE_SOURCES; i++) begin
            if (in_wr[i]) begin
               ref_q[i].push_back(in_data[i*`MERGE_WIDTH +: `MERGE_WIDTH]);
               seen_write = 1'b1;
            end
         end
         stalled = out_valid && !out_ready;
         held_data = out_data;
         held_src = out_src;
      end
      pending = 0;
      for (int i = 0; i < `MERGE_SOURCES; i++)
         pending += ref_q[i].size();
   end

endmodule

// File: verif/stream_merge_tb.sv
// Testbench top: reset, per-test stimulus, error summary and cycle limit
`include "merge_consts.svh"

module stream_merge_tb import merge_pkg::*; ();

   localparam int RESET_CYCLES = 8;
   localparam int IDLE_CYCLES = 10;
   localparam int SINGLE_CYCLES = 24;
   localparam int SAT_CYCLES = 60;
   localparam int BP_CYCLES = 120;
   localparam int FILL_CYCLES = 16;
   localparam int MIX_CYCLES = 200;
   localparam int DRAIN_CYCLES = 40;
   localparam int STIM_CYCLES = RESET_CYCLES + IDLE_CYCLES + SINGLE_CYCLES + SAT_CYCLES +
      BP_CYCLES + FILL_CYCLES + MIX_CYCLES + 5 * DRAIN_CYCLES;
   localparam int MAX_CYCLES = 2 * STIM_CYCLES + 200;

   logic clk;
   logic rstn;
   src_mask_t in_wr;
   logic [`MERGE_SOURCES*`MERGE_WIDTH-1:0] in_data;
   src_mask_t in_full;
   logic out_valid;
   logic out_ready;
   word_t out_data;
   src_t out_src;
   int test_id;
   logic order_en;
   int pending;
   int chk_errors;
   int tb_errors;
   int cycles;
   src_mask_t full_seen;

   tb_clk #(.PERIOD(20)) u_clk (.clk(clk));

   stream_merge uut (.*);

   stream_merge_check chk (.*, .errors(chk_errors));

   // One cycle of random writes to allowed sources that are not full
   task automatic drive_cycle(input src_mask_t allow, input int wr_pct, input int rdy_pct);
      @(negedge clk);
      full_seen = full_seen | in_full;
      for (int i = 0; i < `MERGE_SOURCES; i++) begin
         in_wr[i] = allow[i] && !in_full[i] && (($urandom % 100) < wr_pct);
         in_data[i*`MERGE_WIDTH +: `MERGE_WIDTH] = $urandom;
      end
      out_ready = ($urandom % 100) < rdy_pct;
   endtask

   task automatic run_test(input int id, input int n, input src_mask_t allow,
      input int wr_pct, input int rdy_pct);
      test_id = id;
      repeat (n) drive_cycle(allow, wr_pct, rdy_pct);
   endtask

   // Stop writing and wait until every accepted word is out
   task automatic drain();
      int waited;
      waited = 0;
      @(negedge clk);
      in_wr = '0;
      out_ready = 1'b1;
      while (pending != 0 && waited < DRAIN_CYCLES) begin
         @(negedge clk);
         waited++;
      end
      if (pending != 0) begin
         $display("%0d words were never delivered in test %0d", pending, test_id);
         tb_errors++;
      end
   endtask

   initial begin
      rstn = 1'b0;
      in_wr = '0;
      in_data = '0;
      out_ready = 1'b0;
      test_id = 1;
      order_en = 1'b0;
      tb_errors = 0;
      full_seen = '0;
      void'($urandom(32'hfda23a30));
      repeat (RESET_CYCLES) @(negedge clk);
      rstn = 1'b1;
      run_test(1, IDLE_CYCLES, '0, 0, 100);
      order_en = 1'b1;
      run_test(2, SINGLE_CYCLES, 4'b0100, 60, 100);
      drain();
      // All queues stay busy, so the grant order is strict round robin
      run_test(3, SAT_CYCLES, '1, 100, 100);
      order_en = 1'b0;
      drain();
      run_test(4, BP_CYCLES, '1, 50, 50);
      drain();
      full_seen = '0;
      run_test(5, FILL_CYCLES, 4'b0010, 100, 0);
      if (!full_seen[1]) begin
         $display("in_full[1] never rose while source 1 was filled with out_ready low");
         tb_errors++;
      end
      drain();
      run_test(6, MIX_CYCLES, '1, 40, 70);
      drain();
      $display("errors: checker %0d, testbench %0d", chk_errors, tb_errors);
      if (chk_errors + tb_errors == 0)
         $display("TEST OK");
      else
         $display("TEST FAILED");
      $finish;
   end

   always @(posedge clk) begin
      cycles++;
      if (cycles >= MAX_CYCLES) begin
         $display("run stopped at the limit of %0d cycles", MAX_CYCLES);
         $display("TEST FAILED");
         $finish;
      end
   end

endmodule

// File: verif/tb_clk.sv
// Free-running testbench clock
module tb_clk #(
   parameter int PERIOD = 20
) (
   output logic clk
);

   initial clk = 1'b0;

   always #(PERIOD/2) clk = ~clk;

endmodule

// File: verilog/fwft_fifo.sv
// First-word-fall-through FIFO with write collision bypass and occupancy count
module fwft_fifo #(
   parameter int WIDTH = 32,
   parameter int LOG_DEPTH = 2
) (
   input  logic clk,
   input  logic rstn,
   input  logic wr_en,
   input  logic rd_en,
   input  logic [WIDTH-1:0] wr_data,
   output logic full,
   output logic empty,
   output logic [WIDTH-1:0] rd_data,
   output logic [LOG_DEPTH:0] size
);

   logic [LOG_DEPTH:0] wr_ptr;
   logic [LOG_DEPTH:0] rd_ptr;
   logic [LOG_DEPTH:0] next_rd_ptr;
   logic [WIDTH-1:0] mem [0:(1<<LOG_DEPTH)-1];
   logic [WIDTH-1:0] mem_out;
   logic [WIDTH-1:0] wr_data_q;
   logic collide;

   // Same address, the wrap bit tells full from empty
   assign empty = (wr_ptr == rd_ptr);
   assign full = (wr_ptr[LOG_DEPTH-1:0] == rd_ptr[LOG_DEPTH-1:0]) &&
      (wr_ptr[LOG_DEPTH] != rd_ptr[LOG_DEPTH]);
   assign next_rd_ptr = rd_ptr + {{LOG_DEPTH{1'b0}}, rd_en};

   always_ff @(posedge clk) begin
      if (!rstn) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         collide <= 1'b0;
      end else begin
         if (wr_en)
            wr_ptr <= wr_ptr + 1'b1;
         rd_ptr <= next_rd_ptr;
         // Write lands where the next head is read from
         collide <= wr_en && (wr_ptr == next_rd_ptr);
      end
   end

   // Head prefetch, read-during-write returns the old word
   always_ff @(posedge clk) begin
      if (wr_en)
         mem[wr_ptr[LOG_DEPTH-1:0]] <= wr_data;
      mem_out <= mem[next_rd_ptr[LOG_DEPTH-1:0]];
      wr_data_q <= wr_data;
   end

   assign rd_data = collide ? wr_data_q : mem_out;

   always_ff @(posedge clk) begin
      if (!rstn) begin
         size <= '0;
      end else if (wr_en && !rd_en) begin
         size <= size + 1'b1;
      end else if (rd_en && !wr_en) begin
         size <= size - 1'b1;
      end
   end

   // A full queue takes a write only if it pops in the same cycle
   a_no_overflow: assert property (@(posedge clk) disable iff (!rstn)
      wr_en |-> (!full || rd_en))
      else $error("fwft_fifo: write while full");

   a_no_underflow: assert property (@(posedge clk) disable iff (!rstn)
      rd_en |-> !empty)
      else $error("fwft_fifo: read while empty");

endmodule

// File: verilog/out_stage.sv
// Output stage: head select, pop issue and skid-buffered valid/ready register
module out_stage import merge_pkg::*; (
   input  logic clk,
   input  logic rstn,
   queue_if.outs q,
   output logic out_valid,
   input  logic out_ready,
   output word_t out_data,
   output src_t out_src
);

   logic room;
   word_t in_word;
   word_t skid_data;
   src_t skid_src;

   assign in_word = q.head[q.grant];

   // Room is low only while the skid buffer holds a word
   assign q.pop = q.grant_valid && room;

   always_ff @(posedge clk) begin
      if (!rstn) begin
         room <= 1'b1;
         out_valid <= 1'b0;
      end else begin
         room <= out_ready || !out_valid || (room && !q.pop);
         out_valid <= q.pop || !room || (out_valid && !out_ready);
      end
   end

   // Output register refills from the skid buffer first
   always_ff @(posedge clk) begin
      if (out_ready || !out_valid) begin
         out_data <= room ? in_word : skid_data;
         out_src <= room ? q.grant : skid_src;
      end
      if (room) begin
         skid_data <= in_word;
         skid_src <= q.grant;
      end
   end

   a_hold_stable: assert property (@(posedge clk) disable iff (!rstn)
      (out_valid && !out_ready) |=>
         (out_valid && $stable(out_data) && $stable(out_src)))
      else $error("out_stage: output changed while stalled");

endmodule

// File: verilog/rr_arbiter.sv
// Round-robin arbiter over non-empty queues using a doubled lowest-bit search
`include "merge_consts.svh"

module rr_arbiter import merge_pkg::*; (
   input  logic clk,
   input  logic rstn,
   queue_if.arb q
);

   localparam int N = `MERGE_SOURCES;

   src_t last;
   logic [2*N-1:0] dbl;
   logic [$clog2(2*N)-1:0] hit;

   // Low copy keeps only sources after the last grant
   always_comb begin
      for (int i = 0; i < N; i++) begin
         dbl[i] = q.nonempty[i] && (i > int'(last));
         dbl[N+i] = q.nonempty[i];
      end
   end

   // Scanning down from the top leaves the lowest set bit in hit
   always_comb begin
      hit = '0;
      for (int j = 2*N-1; j >= 0; j--) begin
         if (dbl[j])
            hit = j[$clog2(2*N)-1:0];
      end
   end

   // Low bits of hit fold the upper copy onto the source range
   assign q.grant = src_t'(hit);
   assign q.grant_valid = |q.nonempty;

   // Source 0 goes first out of reset
   always_ff @(posedge clk) begin
      if (!rstn) begin
         last <= src_t'(N-1);
      end else if (q.pop) begin
         last <= q.grant;
      end
   end

   a_grant_nonempty: assert property (@(posedge clk) disable iff (!rstn)
      q.grant_valid |-> q.nonempty[q.grant])
      else $error("rr_arbiter: grant to empty queue %0d", q.grant);

endmodule

// File: verilog/stream_merge.sv
// Four-source stream merger top: queue bank, round-robin arbiter, output stage
`include "merge_consts.svh"

module stream_merge import merge_pkg::*; (
   input  logic clk,
   input  logic rstn,
   input  src_mask_t in_wr,
   input  logic [`MERGE_SOURCES*`MERGE_WIDTH-1:0] in_data,
   output src_mask_t in_full,
   output logic out_valid,
   input  logic out_ready,
   output word_t out_data,
   output src_t out_src
);

   queue_if qi ();

   // Per-source queues
   queue_bank u_bank (
      .clk(clk),
      .rstn(rstn),
      .in_wr(in_wr),
      .in_data(in_data),
      .in_full(in_full),
      .q(qi.bank)
   );

   rr_arbiter u_arb (
      .clk(clk),
      .rstn(rstn),
      .q(qi.arb)
   );

   // Tagged output stream
   out_stage u_out (
      .clk(clk),
      .rstn(rstn),
      .q(qi.outs),
      .out_valid(out_valid),
      .out_ready(out_ready),
      .out_data(out_data),
      .out_src(out_src)
   );

endmodule
